//--- hw/mem_map_pkg.sv
package mem_map_pkg;

    // where a data address lands
    typedef enum logic [1:0] {
        REGION_KERNEL,
        REGION_PROG,
        REGION_MMIO,
        REGION_UNMAPPED
    } mem_region_e;

    // upper address tags
    // kernel is 0x0000_xxxx and read/write
    localparam logic [15:0] KERNEL_TAG = 16'h0000;
    // program is 0x0001_xxxx and read only from the data side
    localparam logic [15:0] PROG_TAG = 16'h0001;
    // mmio page at 0xAAAA_Axxx
    localparam logic [19:0] MMIO_TAG = 20'haaaaa;

    // offset width inside the mmio page
    localparam int MMIO_OFS_W = 12;

    // register offsets within the page
    localparam logic [MMIO_OFS_W-1:0] UART_DATA_OFS = 12'h400;
    localparam logic [MMIO_OFS_W-1:0] UART_STAT_OFS = 12'h404;
    localparam logic [MMIO_OFS_W-1:0] DISP_OFS      = 12'h008;
    localparam logic [MMIO_OFS_W-1:0] LED_OFS       = 12'h00c;

    // uart status word layout
    localparam int UART_TX_FULL_BIT    = 1;
    localparam int UART_RX_PRESENT_BIT = 0;

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

    // data word width of the core
    localparam int XLEN = 32;

    // one enable bit per byte lane
    typedef logic [3:0] byte_en_t;

    // lane word, same 32 bits seen as bytes or halfwords
    // b[0] is bits 7:0, h[0] is bits 15:0
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } lane_word_u;

    // shared ram size in words
    // lower half kernel, upper half program
    localparam int RAM_WORDS = 2048;

    // index is {program bit, addr[11:2]}
    localparam int RAM_IDX_W = 11;

endpackage

//--- hw/ram_port_if.sv
`timescale 1ns/1ps

// data side port of the shared ram
// rdata valid one cycle after an edge with en high
interface ram_port_if import bus_pkg::*; ();

    logic                 en;
    byte_en_t             we;
    logic [RAM_IDX_W-1:0] idx;
    logic [XLEN-1:0]      wdata;
    logic [XLEN-1:0]      rdata;

    // controller owns the strobe and address
    // it also sees the aligned store word for mmio writes
    modport ctrl (output en, we, idx, input wdata);

    // lane unit supplies store data, consumes raw read word
    modport lane (output wdata, input rdata);

    modport ram (input en, we, idx, wdata, output rdata);

endinterface

//--- hw/mmio_if.sv
`timescale 1ns/1ps

// register access path from the controller to the mmio block
// wen/ren are single cycle strobes, rdata follows ofs combinationally
interface mmio_if import bus_pkg::*; import mem_map_pkg::*; ();

    logic                  wen;
    logic                  ren;
    logic [MMIO_OFS_W-1:0] ofs;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       rdata;

    modport ctrl (output wen, ren, ofs, wdata, input rdata);

    modport regs (input wen, ren, ofs, wdata, output rdata);

endinterface

//--- hw/byte_lane_unit.sv
`timescale 1ns/1ps

module byte_lane_unit import bus_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  byte_en_t        dben,
    input  logic [XLEN-1:0] dwdata,
    input  logic            issue,
    ram_port_if.lane        ram,
    output logic [XLEN-1:0] lane_rdata
);

    // enable of the access in flight, used when the read word returns
    byte_en_t   ben_q;
    lane_word_u st_word;
    lane_word_u ld_word;

    // store side
    // low byte or halfword of dwdata moved up to the selected lanes
    always_comb begin
        st_word = '0;
        case (dben)
            4'b0001: st_word.b[0] = dwdata[7:0];
            4'b0010: st_word.b[1] = dwdata[7:0];
            4'b0100: st_word.b[2] = dwdata[7:0];
            4'b1000: st_word.b[3] = dwdata[7:0];
            4'b0011: st_word.h[0] = dwdata[15:0];
            // middle halfword straddles both halves
            4'b0110: begin
                st_word.b[1] = dwdata[7:0];
                st_word.b[2] = dwdata[15:8];
            end
            4'b1100: st_word.h[1] = dwdata[15:0];
            // anything else is a full word
            default: st_word = dwdata;
        endcase
    end

    assign ram.wdata = st_word;

    // enable captured with the ram strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            ben_q <= '0;
        end else if (issue) begin
            ben_q <= dben;
        end
    end

    assign ld_word = ram.rdata;

    // load side
    // pick the addressed lane, zero extend, no sign handling
    always_comb begin
        case (ben_q)
            4'b0001: lane_rdata = {24'h0, ld_word.b[0]};
            4'b0010: lane_rdata = {24'h0, ld_word.b[1]};
            4'b0100: lane_rdata = {24'h0, ld_word.b[2]};
            4'b1000: lane_rdata = {24'h0, ld_word.b[3]};
            4'b0011: lane_rdata = {16'h0, ld_word.h[0]};
            4'b0110: lane_rdata = {16'h0, ld_word.b[2], ld_word.b[1]};
            4'b1100: lane_rdata = {16'h0, ld_word.h[1]};
            default: lane_rdata = ld_word;
        endcase
    end

endmodule

//--- hw/shared_ram.sv
`timescale 1ns/1ps

module shared_ram import bus_pkg::*; (
    input  logic                 clk,
    input  logic                 imem_en,
    input  logic [RAM_IDX_W-1:0] imem_idx,
    output logic [XLEN-1:0]      imem_dout,
    ram_port_if.ram              ram
);

    logic [XLEN-1:0] mem [RAM_WORDS];

    // contents start at zero, no program loader here
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // instruction port
    // read only, one word per cycle
    always_ff @(posedge clk) begin
        if (imem_en) begin
            imem_dout <= mem[imem_idx];
        end
    end

    // data port
    // byte masked write, read returns the old word
    always_ff @(posedge clk) begin
        if (ram.en) begin
            for (int b = 0; b < 4; b++) begin
                if (ram.we[b]) begin
                    mem[ram.idx][b*8 +: 8] <= ram.wdata[b*8 +: 8];
                end
            end
            ram.rdata <= mem[ram.idx];
        end
    end

    // only an unknown index can miss the array
    a_idx_in_range: assert property (
        @(posedge clk) ram.en |-> !$isunknown(ram.idx)
    );

endmodule

//--- hw/mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs import bus_pkg::*; import mem_map_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    mmio_if.regs            mmio,
    output logic [7:0]      tx_byte,
    output logic            tx_valid,
    input  logic            tx_ready,
    input  logic [7:0]      rx_byte,
    input  logic            rx_valid,
    output logic [XLEN-1:0] disp_dat,
    output logic [15:0]     led
);

    logic [7:0]      rx_hold;
    logic            rx_present;
    logic            tx_load;
    logic            rx_take;
    logic [XLEN-1:0] stat_word;

    // tx holding register only accepts when empty
    assign tx_load = mmio.wen && (mmio.ofs == UART_DATA_OFS) && !tx_valid;
    // reading the data register consumes the rx byte
    assign rx_take = mmio.ren && (mmio.ofs == UART_DATA_OFS);

    // tx handshake
    // drain has priority, a write while full is lost
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            tx_valid <= 1'b0;
        end else if (tx_load) begin
            tx_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_byte <= mmio.wdata[7:0];
        end
    end

    // rx side, newest byte wins
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_present <= 1'b0;
        end else if (rx_valid) begin
            rx_present <= 1'b1;
        end else if (rx_take) begin
            rx_present <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_hold <= rx_byte;
        end
    end

    // display and led registers
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_dat <= '0;
            led      <= '0;
        end else if (mmio.wen) begin
            if (mmio.ofs == DISP_OFS) begin
                disp_dat <= mmio.wdata;
            end
            // led keeps the low half only
            if (mmio.ofs == LED_OFS) begin
                led <= mmio.wdata[15:0];
            end
        end
    end

    // status, tx full mirrors tx_valid
    always_comb begin
        stat_word                      = '0;
        stat_word[UART_TX_FULL_BIT]    = tx_valid;
        stat_word[UART_RX_PRESENT_BIT] = rx_present;
    end

    // read mux
    always_comb begin
        case (mmio.ofs)
            UART_DATA_OFS: mmio.rdata = {24'h0, rx_hold};
            UART_STAT_OFS: mmio.rdata = stat_word;
            DISP_OFS:      mmio.rdata = disp_dat;
            LED_OFS:       mmio.rdata = {16'h0, led};
            default:       mmio.rdata = '0;
        endcase
    end

    // access strobes last one cycle, a longer one would consume two rx bytes
    a_strobe_one_cycle: assert property (
        @(posedge clk) disable iff (rst) (mmio.wen || mmio.ren) |=> !(mmio.wen || mmio.ren)
    );

endmodule

//--- hw/mem_controller.sv
`timescale 1ns/1ps

module mem_controller import bus_pkg::*; import mem_map_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            dreq,
    output logic            dack,
    input  logic [XLEN-1:0] daddr,
    input  logic            dwe,
    input  byte_en_t        dben,
    output logic [XLEN-1:0] drdata,
    input  logic [XLEN-1:0] lane_rdata,
    ram_port_if.ctrl        ram,
    mmio_if.ctrl            mmio
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_DONE
    } ctrl_state_e;

    ctrl_state_e     state;
    mem_region_e     region;
    logic            issuing;
    logic            to_mmio;
    logic [XLEN-1:0] mmio_rdata_q;

    // region decode, core holds daddr for the whole transfer
    always_comb begin
        if (daddr[31:16] == KERNEL_TAG) begin
            region = REGION_KERNEL;
        end else if (daddr[31:16] == PROG_TAG) begin
            region = REGION_PROG;
        end else if (daddr[31:12] == MMIO_TAG) begin
            region = REGION_MMIO;
        end else begin
            region = REGION_UNMAPPED;
        end
    end

    assign issuing = (state == ST_ISSUE);
    assign to_mmio = issuing && (region == REGION_MMIO);

    // ram strobe for both ram regions
    // writes only land in kernel space
    assign ram.en  = issuing && ((region == REGION_KERNEL) || (region == REGION_PROG));
    assign ram.we  = (issuing && (region == REGION_KERNEL) && dwe) ? dben : '0;
    assign ram.idx = {daddr[16], daddr[11:2]};

    // mmio strobes, data is the lane aligned store word
    assign mmio.wen   = to_mmio && dwe;
    assign mmio.ren   = to_mmio && !dwe;
    assign mmio.ofs   = to_mmio ? daddr[MMIO_OFS_W-1:0] : '0;
    assign mmio.wdata = (to_mmio && dwe) ? ram.wdata : '0;

    // idle -> issue -> done, done waits for dreq to drop
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            dack  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dreq) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: state <= ST_DONE;
                ST_DONE: begin
                    if (!dack) begin
                        dack <= 1'b1;
                    end else if (!dreq) begin
                        dack  <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // mmio read value sampled while ofs is presented
    always_ff @(posedge clk) begin
        if (issuing) begin
            mmio_rdata_q <= mmio.rdata;
        end
    end

    // read return, captured together with dack rising
    always_ff @(posedge clk) begin
        if ((state == ST_DONE) && !dack && !dwe) begin
            case (region)
                REGION_KERNEL, REGION_PROG: drdata <= lane_rdata;
                REGION_MMIO:                drdata <= mmio_rdata_q;
                default:                    drdata <= '0;
            endcase
        end
    end

    // ack only answers a request seen on the edge before
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(dack) |-> $past(dreq)
    );

    // never both ram and mmio written in one cycle
    a_one_target: assert property (
        @(posedge clk) disable iff (rst) !(ram.en && mmio.wen)
    );

endmodule

//--- hw/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top import bus_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // instruction fetch
    input  logic            imem_en,
    input  logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] imem_dout,
    // data req/ack port
    input  logic            dreq,
    output logic            dack,
    input  logic [XLEN-1:0] daddr,
    input  logic            dwe,
    input  logic [3:0]      dben,
    input  logic [XLEN-1:0] dwdata,
    output logic [XLEN-1:0] drdata,
    // uart byte streams
    output logic [7:0]      tx_byte,
    output logic            tx_valid,
    input  logic            tx_ready,
    input  logic [7:0]      rx_byte,
    input  logic            rx_valid,
    // board outputs
    output logic [XLEN-1:0] disp_dat,
    output logic [15:0]     led
);

    ram_port_if ram_bus ();
    mmio_if     mmio_bus ();

    // extracted load word back to the controller
    logic [XLEN-1:0] lane_rdata;

    mem_controller i_mem_controller (
        .clk        (clk),
        .rst        (rst),
        .dreq       (dreq),
        .dack       (dack),
        .daddr      (daddr),
        .dwe        (dwe),
        .dben       (dben),
        .drdata     (drdata),
        .lane_rdata (lane_rdata),
        .ram        (ram_bus.ctrl),
        .mmio       (mmio_bus.ctrl)
    );

    // lane enable is latched on the ram strobe
    byte_lane_unit i_byte_lane_unit (
        .clk        (clk),
        .rst        (rst),
        .dben       (dben),
        .dwdata     (dwdata),
        .issue      (ram_bus.en),
        .ram        (ram_bus.lane),
        .lane_rdata (lane_rdata)
    );

    // fetch index is the word address, bit 12 picks the program half
    shared_ram i_shared_ram (
        .clk       (clk),
        .imem_en   (imem_en),
        .imem_idx  (imem_addr[RAM_IDX_W+1:2]),
        .imem_dout (imem_dout),
        .ram       (ram_bus.ram)
    );

    mmio_regs i_mmio_regs (
        .clk      (clk),
        .rst      (rst),
        .mmio     (mmio_bus.regs),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .disp_dat (disp_dat),
        .led      (led)
    );

endmodule

//--- test/tb_mem_vectors.svh
// stimulus table for tb_mem_subsystem
// columns: kind, address, write, enables, write data, expected

// row kinds
localparam int OP_DATA  = 0;
localparam int OP_FETCH = 1;
// tx_valid in bit 8 of expected, tx_byte in bits 7:0
localparam int OP_TX    = 2;
localparam int OP_DRAIN = 3;
// received byte taken from the write data column
localparam int OP_RX    = 4;
localparam int OP_DISP  = 5;
localparam int OP_LED   = 6;

task automatic build_table();
    // outputs straight out of reset
    add_row(OP_DISP,  32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_row(OP_LED,   32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_row(OP_TX,    32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    // every lane pattern on one kernel word
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b1111, 32'h1122_3344, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b1111, 32'h0000_0000, 32'h1122_3344);
    // upper bits of the store data must be ignored
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b0001, 32'hffff_ffab, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b0001, 32'h0000_0000, 32'h0000_00ab);
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b0010, 32'h0000_00cd, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b0010, 32'h0000_0000, 32'h0000_00cd);
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b0100, 32'h0000_00ef, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b0100, 32'h0000_0000, 32'h0000_00ef);
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b1000, 32'h0000_0099, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b1000, 32'h0000_0000, 32'h0000_0099);
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b0011, 32'h7777_beef, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b0011, 32'h0000_0000, 32'h0000_beef);
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b1100, 32'h0000_5a5a, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b1100, 32'h0000_0000, 32'h0000_5a5a);
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b0110, 32'h0000_1234, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b0110, 32'h0000_0000, 32'h0000_1234);
    // odd mask, word kept whole but only lanes 0 and 2 written
    add_row(OP_DATA,  32'h0000_0100, 1'b1, 4'b0101, 32'hcafe_f00d, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b1111, 32'h0000_0000, 32'h5afe_340d);
    // same word seen from the fetch side
    add_row(OP_FETCH, 32'h0000_0100, 1'b0, 4'b0000, 32'h0000_0000, 32'h5afe_340d);
    // program region is read only from the data port
    add_row(OP_DATA,  32'h0001_0100, 1'b1, 4'b1111, 32'hffff_ffff, 32'h0000_0000);
    add_row(OP_DATA,  32'h0001_0100, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0000);
    add_row(OP_FETCH, 32'h0000_1100, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_row(OP_DATA,  32'h0000_0100, 1'b0, 4'b1111, 32'h0000_0000, 32'h5afe_340d);
    add_row(OP_DATA,  32'h2000_0000, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0000);
    // uart transmit, second byte hits a full register
    add_row(OP_DATA,  32'haaaa_a400, 1'b1, 4'b1111, 32'h0000_0041, 32'h0000_0000);
    add_row(OP_TX,    32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0141);
    add_row(OP_DATA,  32'haaaa_a404, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0002);
    add_row(OP_DATA,  32'haaaa_a400, 1'b1, 4'b1111, 32'h0000_0042, 32'h0000_0000);
    add_row(OP_TX,    32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0141);
    add_row(OP_DRAIN, 32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_row(OP_TX,    32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_0000);
    add_row(OP_DATA,  32'haaaa_a404, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0000);
    // uart receive, read of the data register clears the flag
    add_row(OP_RX,    32'h0000_0000, 1'b0, 4'b0000, 32'h0000_005c, 32'h0000_0000);
    add_row(OP_DATA,  32'haaaa_a404, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0001);
    add_row(OP_DATA,  32'haaaa_a400, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_005c);
    add_row(OP_DATA,  32'haaaa_a404, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0000);
    // display and led, led keeps the low half
    add_row(OP_DATA,  32'haaaa_a008, 1'b1, 4'b1111, 32'h1234_5678, 32'h0000_0000);
    add_row(OP_DISP,  32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h1234_5678);
    add_row(OP_DATA,  32'haaaa_a00c, 1'b1, 4'b1111, 32'hffff_c3a5, 32'h0000_0000);
    add_row(OP_LED,   32'h0000_0000, 1'b0, 4'b0000, 32'h0000_0000, 32'h0000_c3a5);
    add_row(OP_DATA,  32'haaaa_a00c, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_c3a5);
    // unused mmio offset
    add_row(OP_DATA,  32'haaaa_a010, 1'b0, 4'b1111, 32'h0000_0000, 32'h0000_0000);
endtask

//--- test/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem import bus_pkg::*; import mem_map_pkg::*; ();

    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int RST_CYCLES  = 5;
    localparam int WAIT_LIMIT  = 16;
    localparam int ACK_CYCLES  = 2;

    logic            clk;
    logic            rst;
    logic            imem_en;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_dout;
    logic            dreq;
    logic            dack;
    logic [XLEN-1:0] daddr;
    logic            dwe;
    byte_en_t        dben;
    logic [XLEN-1:0] dwdata;
    logic [XLEN-1:0] drdata;
    logic [7:0]      tx_byte;
    logic            tx_valid;
    logic            tx_ready;
    logic [7:0]      rx_byte;
    logic            rx_valid;
    logic [XLEN-1:0] disp_dat;
    logic [15:0]     led;

    int errors;

    // reference ram image, same indexing as the address map
    logic [XLEN-1:0] ref_mem [RAM_WORDS];

    // table columns
    int              vec_kind  [$];
    logic [XLEN-1:0] vec_addr  [$];
    logic            vec_we    [$];
    byte_en_t        vec_ben   [$];
    logic [XLEN-1:0] vec_wdata [$];
    logic [XLEN-1:0] vec_exp   [$];

    task automatic add_row(input int kind, input logic [XLEN-1:0] addr, input logic we,
                           input byte_en_t ben, input logic [XLEN-1:0] wdata,
                           input logic [XLEN-1:0] exp);
        vec_kind.push_back(kind);
        vec_addr.push_back(addr);
        vec_we.push_back(we);
        vec_ben.push_back(ben);
        vec_wdata.push_back(wdata);
        vec_exp.push_back(exp);
    endtask

    `include "tb_mem_vectors.svh"

    mem_subsystem_top i_mem_subsystem_top (
        .clk       (clk),
        .rst       (rst),
        .imem_en   (imem_en),
        .imem_addr (imem_addr),
        .imem_dout (imem_dout),
        .dreq      (dreq),
        .dack      (dack),
        .daddr     (daddr),
        .dwe       (dwe),
        .dben      (dben),
        .dwdata    (dwdata),
        .drdata    (drdata),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .disp_dat  (disp_dat),
        .led       (led)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // hand-worked table value against the model
    task automatic table_agrees(input int row, input logic [XLEN-1:0] model);
        if (model !== vec_exp[row]) begin
            errors++;
            $display("row %0d: table holds %h but the reference model gives %h",
                     row, vec_exp[row], model);
        end
    endtask

    function automatic mem_region_e addr_region(input logic [XLEN-1:0] addr);
        if (addr[31:16] == KERNEL_TAG) begin
            return REGION_KERNEL;
        end else if (addr[31:16] == PROG_TAG) begin
            return REGION_PROG;
        end else if (addr[31:12] == MMIO_TAG) begin
            return REGION_MMIO;
        end
        return REGION_UNMAPPED;
    endfunction

    // program bit then word bits
    function automatic int ram_index(input logic [XLEN-1:0] addr);
        return int'({addr[16], addr[11:2]});
    endfunction

    // bytes moved by an access, narrow patterns only
    function automatic int lane_width(input byte_en_t ben);
        case (ben)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1;
            4'b0011, 4'b0110, 4'b1100: return 2;
            default: return 4;
        endcase
    endfunction

    // lowest enabled lane is where the narrow value sits
    function automatic int lane_base(input byte_en_t ben);
        if (lane_width(ben) == 4) begin
            return 0;
        end
        for (int i = 0; i < 4; i++) begin
            if (ben[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic logic [XLEN-1:0] lane_mask(input int width);
        if (width >= 4) begin
            return '1;
        end
        return (32'h1 << (8 * width)) - 32'h1;
    endfunction

    task automatic model_store(input logic [XLEN-1:0] addr, input byte_en_t ben,
                               input logic [XLEN-1:0] wdata);
        logic [XLEN-1:0] aligned;
        int              idx;
        // only the kernel region takes data port stores
        if (addr_region(addr) != REGION_KERNEL) begin
            return;
        end
        idx     = ram_index(addr);
        aligned = (wdata & lane_mask(lane_width(ben))) << (8 * lane_base(ben));
        for (int b = 0; b < 4; b++) begin
            if (ben[b]) begin
                ref_mem[idx][b*8 +: 8] = aligned[b*8 +: 8];
            end
        end
    endtask

    function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] addr,
                                                   input byte_en_t ben);
        logic [XLEN-1:0] word;
        if (addr_region(addr) == REGION_UNMAPPED) begin
            return '0;
        end
        word = ref_mem[ram_index(addr)] >> (8 * lane_base(ben));
        return word & lane_mask(lane_width(ben));
    endfunction

    // four phase transfer, entered and left 2 ns after an edge
    task automatic data_xfer(input logic [XLEN-1:0] addr, input logic we, input byte_en_t ben,
                             input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
        int n;
        rdata  = 'x;
        daddr  = addr;
        dwe    = we;
        dben   = ben;
        dwdata = wdata;
        dreq   = 1'b1;
        // this edge sees dreq with the controller idle
        @(posedge clk);
        n = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end while (!dack && n < WAIT_LIMIT);
        if (!dack) begin
            errors++;
            $display("dack never rose for address %h within %0d cycles", addr, WAIT_LIMIT);
            dreq = 1'b0;
            return;
        end
        if (n != ACK_CYCLES) begin
            errors++;
            $display("ERROR %0t dack latency expected %0d actual %0d", $time, ACK_CYCLES, n);
        end
        rdata = drdata;
        dreq  = 1'b0;
        n     = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end while (dack && n < WAIT_LIMIT);
        if (dack) begin
            errors++;
            $display("dack stayed high after dreq dropped for address %h", addr);
        end
    endtask

    // one fetch, word shows up after the next edge
    task automatic fetch_word(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] word);
        imem_addr = addr;
        imem_en   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        imem_en = 1'b0;
        word    = imem_dout;
    endtask

    task automatic drain_tx();
        int n;
        tx_ready = 1'b1;
        n        = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end while (tx_valid && n < WAIT_LIMIT);
        tx_ready = 1'b0;
        if (tx_valid) begin
            errors++;
            $display("tx_valid never fell while tx_ready was held high");
        end
    endtask

    task automatic pulse_rx(input logic [7:0] data);
        rx_byte  = data;
        rx_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        rx_valid = 1'b0;
    endtask

    initial begin
        logic [XLEN-1:0] got;
        logic [XLEN-1:0] want;
        errors    = 0;
        rst       = 1'b1;
        imem_en   = 1'b0;
        imem_addr = '0;
        dreq      = 1'b0;
        daddr     = '0;
        dwe       = 1'b0;
        dben      = '0;
        dwdata    = '0;
        tx_ready  = 1'b0;
        rx_byte   = '0;
        rx_valid  = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_flag("dack", 1'b0, dack);
        for (int i = 0; i < vec_kind.size(); i++) begin
            case (vec_kind[i])
                OP_DATA: begin
                    data_xfer(vec_addr[i], vec_we[i], vec_ben[i], vec_wdata[i], got);
                    if (vec_we[i]) begin
                        model_store(vec_addr[i], vec_ben[i], vec_wdata[i]);
                    end else if (addr_region(vec_addr[i]) == REGION_MMIO) begin
                        check_word("drdata", vec_exp[i], got);
                    end else begin
                        want = model_load(vec_addr[i], vec_ben[i]);
                        table_agrees(i, want);
                        check_word("drdata", want, got);
                    end
                end
                OP_FETCH: begin
                    fetch_word(vec_addr[i], got);
                    want = ref_mem[int'(vec_addr[i][12:2])];
                    table_agrees(i, want);
                    check_word("imem_dout", want, got);
                end
                OP_TX: begin
                    check_flag("tx_valid", vec_exp[i][8], tx_valid);
                    if (vec_exp[i][8]) begin
                        check_byte("tx_byte", vec_exp[i][7:0], tx_byte);
                    end
                end
                OP_DRAIN: drain_tx();
                OP_RX:    pulse_rx(vec_wdata[i][7:0]);
                OP_DISP:  check_word("disp_dat", vec_exp[i], disp_dat);
                OP_LED:   check_word("led", vec_exp[i], {16'h0, led});
                default: begin
                    errors++;
                    $display("row %0d has an unknown kind %0d", i, vec_kind[i]);
                end
            endcase
        end
        $display("rows: %0d  errors: %0d", vec_kind.size(), errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+test
hw/mem_map_pkg.sv
hw/bus_pkg.sv
hw/ram_port_if.sv
hw/mmio_if.sv
hw/byte_lane_unit.sv
hw/shared_ram.sv
hw/mmio_regs.sv
hw/mem_controller.sv
hw/mem_subsystem_top.sv
test/tb_mem_subsystem.sv
